//--- Makefile
# Verilator build and run of the DMR core cluster testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_core_cluster
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_clock_gen.sv
/*
 * Clock and reset source for the testbench.
 * 20 ns clock, reset held high for the first 8 rising edges.
 */

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;  // Released on an edge like the other inputs
  end

endmodule : tb_clock_gen

//--- bench/tb_core_cluster.sv
/*
 * Testbench for the DMR core cluster with four cores.
 * Random strobes run in split mode, then with pair 0 in DMR mode, while a
 * reference model predicts every output and register read each cycle.
 */

`timescale 1ns/100ps

module tb_core_cluster;

  localparam int NUM_CORES    = 4;
  localparam int NUM_PAIRS    = NUM_CORES / 2;
  localparam int SPLIT_CYCLES = 40;
  localparam int DMR_CYCLES   = 40;
  localparam int TAIL_CYCLES  = 10;
  localparam int TEST_CYCLES  = 8 + SPLIT_CYCLES + DMR_CYCLES + TAIL_CYCLES + 60;
  localparam int LIMIT_CYCLES = 2 * TEST_CYCLES;  // Generous margin

  logic                                          clk;
  logic                                          reset;
  logic [hmr_pkg::ID_W-1:0]                      hart_id_base;
  logic [NUM_CORES-1:0]                          in_valid;
  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0]     in_data;
  logic                                          reg_we;
  logic                                          reg_re;
  logic [hmr_pkg::REG_AW-1:0]                    reg_addr;
  logic [hmr_pkg::REG_DW-1:0]                    reg_wdata;
  logic [NUM_CORES-1:0]                          out_valid;
  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0]     out_data;
  logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]       out_id;
  logic [hmr_pkg::REG_DW-1:0]                    reg_rdata;
  logic [NUM_PAIRS-1:0]                          dmr_error;

  integer seed = 32'hccf0;
  int     errors;
  int     err_pulses [NUM_PAIRS];  // Error pulses seen on the DUT

  // Reference model state, valid after each rising edge
  logic [hmr_pkg::DATA_W-1:0] m_acc [NUM_CORES];
  logic [NUM_CORES-1:0]       m_rv;
  logic [hmr_pkg::DATA_W-1:0] m_rd  [NUM_CORES];
  logic [hmr_pkg::ID_W-1:0]   m_rid [NUM_CORES];
  logic [NUM_PAIRS-1:0]       m_setback;
  logic [NUM_PAIRS-1:0]       m_en;
  logic [hmr_pkg::CNT_W-1:0]  m_cnt [NUM_PAIRS];
  logic [hmr_pkg::REG_DW-1:0] m_rdata;

  tb_clock_gen u_clock_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  core_cluster #(
    .NUM_CORES ( NUM_CORES )
  ) u_core_cluster (
    .clk_i          ( clk          ),
    .reset_i        ( reset        ),
    .hart_id_base_i ( hart_id_base ),
    .in_valid_i     ( in_valid     ),
    .in_data_i      ( in_data      ),
    .reg_we_i       ( reg_we       ),
    .reg_re_i       ( reg_re       ),
    .reg_addr_i     ( reg_addr     ),
    .reg_wdata_i    ( reg_wdata    ),
    .out_valid_o    ( out_valid    ),
    .out_data_o     ( out_data     ),
    .out_id_o       ( out_id       ),
    .reg_rdata_o    ( reg_rdata    ),
    .dmr_error_o    ( dmr_error    )
  );

  task automatic check_word(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
    end
  endtask

  // Core sum after one edge, setback restarts from zero
  function automatic logic [hmr_pkg::DATA_W-1:0] ref_acc(
    input logic [hmr_pkg::DATA_W-1:0] acc,
    input logic                       setback,
    input logic                       valid,
    input logic [hmr_pkg::DATA_W-1:0] data
  );
    logic [hmr_pkg::DATA_W-1:0] base;
    base = setback ? '0 : acc;
    return valid ? base + data : base;
  endfunction

  // Both results present in DMR mode but data or id differ
  function automatic logic ref_mismatch(input int pair);
    logic differ;
    differ = (m_rd[2*pair] != m_rd[2*pair+1]) || (m_rid[2*pair] != m_rid[2*pair+1]);
    return m_en[pair] && m_rv[2*pair] && m_rv[2*pair+1] && differ;
  endfunction

  function automatic logic [hmr_pkg::REG_DW-1:0] ref_rdata(input logic [hmr_pkg::REG_AW-1:0] addr);
    logic [hmr_pkg::REG_DW-1:0] val;
    val = '0;
    if (addr == hmr_pkg::ADDR_DMR_EN) val[NUM_PAIRS-1:0] = m_en;
    for (int p = 0; p < NUM_PAIRS; p++) begin
      if (addr == hmr_pkg::ADDR_ERR_BASE + p) val[hmr_pkg::CNT_W-1:0] = m_cnt[p];
    end
    return val;
  endfunction

  task automatic reset_model();
    m_rv      = '0;
    m_setback = '0;
    m_en      = '0;
    m_rdata   = '0;
    for (int i = 0; i < NUM_CORES; i++) m_acc[i] = '0;
    for (int p = 0; p < NUM_PAIRS; p++) begin
      m_cnt[p]      = '0;
      err_pulses[p] = 0;
    end
  endtask

  // Moves the model across the next edge with the inputs now applied
  task automatic advance_model(input logic [NUM_PAIRS-1:0] mism);
    int pair;
    int lead;
    logic [hmr_pkg::DATA_W-1:0] nxt;
    if (reg_re) m_rdata = ref_rdata(reg_addr);  // Old register values
    for (int i = 0; i < NUM_CORES; i++) begin
      pair = i / 2;
      lead = m_en[pair] ? 2 * pair : i;  // Leader feeds both cores in DMR
      nxt = ref_acc(m_acc[i], m_setback[pair], in_valid[lead], in_data[lead]);
      m_acc[i] = nxt;
      m_rv[i]  = in_valid[lead];
      if (in_valid[lead]) begin
        m_rd[i]  = nxt;
        m_rid[i] = hart_id_base + lead;
      end
    end
    for (int p = 0; p < NUM_PAIRS; p++) begin
      m_setback[p] = mism[p];
      if (reg_we && reg_addr == hmr_pkg::ADDR_ERR_BASE + p) begin
        m_cnt[p] = '0;
      end else if (mism[p] && m_cnt[p] != 8'hff) begin
        m_cnt[p] = m_cnt[p] + 1'b1;
      end
    end
    if (reg_we && reg_addr == hmr_pkg::ADDR_DMR_EN) m_en = reg_wdata[NUM_PAIRS-1:0];
  endtask

  // Compare on the falling edge where all outputs are settled
  always @(negedge clk) begin : compare
    logic [NUM_PAIRS-1:0] mism;
    logic [NUM_CORES-1:0] exp_valid;
    if (reset) begin
      reset_model();
    end else begin
      for (int p = 0; p < NUM_PAIRS; p++) begin
        mism[p]            = ref_mismatch(p);
        exp_valid[2*p]     = m_rv[2*p] & ~mism[p];
        exp_valid[2*p + 1] = m_rv[2*p + 1] & ~m_en[p];  // Follower silent
        if (dmr_error[p]) err_pulses[p]++;
      end
      check_word("out_valid_o", exp_valid, out_valid);
      check_word("dmr_error_o", mism, dmr_error);
      check_word("reg_rdata_o", m_rdata, reg_rdata);
      for (int i = 0; i < NUM_CORES; i++) begin
        if (exp_valid[i]) begin
          check_word($sformatf("out_data_o[%0d]", i), m_rd[i], out_data[i]);
          check_word($sformatf("out_id_o[%0d]", i), m_rid[i], out_id[i]);
        end
      end
      advance_model(mism);
    end
  end

  // One cycle of inputs, driven on the rising edge
  task automatic drive(input logic [NUM_CORES-1:0] valid,
                       input logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] data,
                       input logic we, input logic re,
                       input logic [hmr_pkg::REG_AW-1:0] addr,
                       input logic [hmr_pkg::REG_DW-1:0] wdata);
    @(posedge clk);
    in_valid  <= valid;
    in_data   <= data;
    reg_we    <= we;
    reg_re    <= re;
    reg_addr  <= addr;
    reg_wdata <= wdata;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) drive('0, '0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic reg_write(input logic [hmr_pkg::REG_AW-1:0] addr,
                           input logic [hmr_pkg::REG_DW-1:0] wdata);
    drive('0, '0, 1'b1, 1'b0, addr, wdata);
  endtask

  task automatic read_expect(input logic [hmr_pkg::REG_AW-1:0] addr,
                             input logic [hmr_pkg::REG_DW-1:0] exp_val);
    drive('0, '0, 1'b0, 1'b1, addr, '0);
    idle(1);
    @(negedge clk);
    check_word($sformatf("reg_rdata_o @%0h", addr), exp_val, reg_rdata);
  endtask

  task automatic random_strobe();
    logic [NUM_CORES-1:0]                      mask;
    logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] data;
    mask = $random(seed);
    for (int i = 0; i < NUM_CORES; i++) data[i] = $random(seed);
    drive(mask, data, 1'b0, 1'b0, '0, '0);
  endtask

  initial begin : stimulus
    logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] data;
    hart_id_base = 16'h0a40;
    in_valid     = '0;
    in_data      = '0;
    reg_we       = 1'b0;
    reg_re       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    errors       = 0;
    wait (reset === 1'b0);

    // Registers clear after reset
    idle(2);
    read_expect(hmr_pkg::ADDR_DMR_EN, 0);
    read_expect(hmr_pkg::ADDR_ERR_BASE, 0);
    read_expect(hmr_pkg::ADDR_ERR_BASE + 1, 0);

    repeat (SPLIT_CYCLES) random_strobe();
    idle(1);
    if (m_acc[0] == m_acc[1]) begin  // Pair 0 must hold different sums
      data    = '0;
      data[1] = 1;
      drive(4'b0010, data, 1'b0, 1'b0, '0, '0);
      idle(1);
    end

    // First common strobe after enabling DMR on pair 0 must mismatch
    reg_write(hmr_pkg::ADDR_DMR_EN, 1);
    for (int i = 0; i < NUM_CORES; i++) data[i] = $random(seed);
    drive(4'b0011, data, 1'b0, 1'b0, '0, '0);
    idle(3);
    check_word("dmr_error_o[0] pulse count", 1, err_pulses[0]);
    read_expect(hmr_pkg::ADDR_ERR_BASE, 1);

    // Sums restarted by the setback
    for (int i = 0; i < NUM_CORES; i++) data[i] = $random(seed);
    drive(4'b0001, data, 1'b0, 1'b0, '0, '0);
    idle(1);
    @(negedge clk);
    check_word("out_valid_o", 4'b0001, out_valid);
    check_word("out_data_o[0]", data[0], out_data[0]);

    // Pair 0 in lockstep, pair 1 still split
    repeat (DMR_CYCLES) random_strobe();
    idle(2);
    check_word("dmr_error_o[0] pulse count", 1, err_pulses[0]);
    check_word("dmr_error_o[1] pulse count", 0, err_pulses[1]);
    read_expect(hmr_pkg::ADDR_DMR_EN, 1);
    read_expect(hmr_pkg::ADDR_ERR_BASE, 1);
    read_expect(hmr_pkg::ADDR_ERR_BASE + 1, 0);

    reg_write(hmr_pkg::ADDR_ERR_BASE, 32'hdead_beef);  // Any data clears
    read_expect(hmr_pkg::ADDR_ERR_BASE, 0);
    read_expect(8'h7f, 0);
    reg_write(hmr_pkg::ADDR_DMR_EN, 3);
    read_expect(hmr_pkg::ADDR_DMR_EN, 3);
    reg_write(hmr_pkg::ADDR_DMR_EN, 0);

    repeat (TAIL_CYCLES) random_strobe();
    idle(2);

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, stimulus never finished", LIMIT_CYCLES);
    $display("Run stopped with %0d errors", errors);
    $display("Simulation failed");
    $finish;
  end

endmodule : tb_core_cluster

//--- build.f
logic/hmr_pkg.sv
logic/work_core.sv
logic/dmr_checker.sv
logic/hmr_regs.sv
logic/hmr_unit.sv
logic/core_cluster.sv
bench/tb_clock_gen.sv
bench/tb_core_cluster.sv

//--- logic/core_cluster.sv
/*
 * Top level of the DMR core cluster.
 * Binds the system ports to the redundancy unit, gives core i the hart id
 * base plus i, and hangs NUM_CORES accumulator cores behind the unit.
 */

`timescale 1ns/100ps

module core_cluster #(
  parameter  int unsigned NUM_CORES = 4,  // Must be even
  localparam int unsigned NUM_PAIRS = NUM_CORES / 2
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [hmr_pkg::ID_W-1:0]                hart_id_base_i,
  input  logic [NUM_CORES-1:0]                    in_valid_i,
  input  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] in_data_i,
  input  logic                                    reg_we_i,
  input  logic                                    reg_re_i,
  input  logic [hmr_pkg::REG_AW-1:0]              reg_addr_i,
  input  logic [hmr_pkg::REG_DW-1:0]              reg_wdata_i,
  output logic [NUM_CORES-1:0]                    out_valid_o,
  output logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] out_data_o,
  output logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   out_id_o,
  output logic [hmr_pkg::REG_DW-1:0]              reg_rdata_o,
  output logic [NUM_PAIRS-1:0]                    dmr_error_o
);

  logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   sys_id;
  logic [NUM_CORES-1:0]                      core_valid;
  logic [NUM_CORES-1:0]                      core_setback;
  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] core_data;
  logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   core_id;
  logic [NUM_CORES-1:0]                      res_valid;
  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] res_data;
  logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   res_id;

  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_cores
    localparam logic [hmr_pkg::ID_W-1:0] ID_OFS = i;

    assign sys_id[i] = hart_id_base_i + ID_OFS;  // Per-core hart id

    work_core u_work_core (
      .clk_i     ( clk_i           ),
      .reset_i   ( reset_i         ),
      .setback_i ( core_setback[i] ),
      .valid_i   ( core_valid[i]   ),
      .data_i    ( core_data[i]    ),
      .hart_id_i ( core_id[i]      ),
      .valid_o   ( res_valid[i]    ),
      .data_o    ( res_data[i]     ),
      .id_o      ( res_id[i]       )
    );
  end

  hmr_unit #(
    .NUM_CORES ( NUM_CORES )
  ) u_hmr_unit (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .reg_we_i       ( reg_we_i     ),
    .reg_re_i       ( reg_re_i     ),
    .reg_addr_i     ( reg_addr_i   ),
    .reg_wdata_i    ( reg_wdata_i  ),
    .reg_rdata_o    ( reg_rdata_o  ),
    .sys_valid_i    ( in_valid_i   ),
    .sys_data_i     ( in_data_i    ),
    .sys_id_i       ( sys_id       ),
    .sys_valid_o    ( out_valid_o  ),
    .sys_data_o     ( out_data_o   ),
    .sys_id_o       ( out_id_o     ),
    .core_valid_o   ( core_valid   ),
    .core_data_o    ( core_data    ),
    .core_id_o      ( core_id      ),
    .core_setback_o ( core_setback ),
    .core_valid_i   ( res_valid    ),
    .core_data_i    ( res_data     ),
    .core_id_i      ( res_id       ),
    .dmr_error_o    ( dmr_error_o  )
  );

endmodule : core_cluster

//--- logic/dmr_checker.sv
/*
 * Lockstep checker for one pair of cores, lane 0 being the leader.
 * Split mode passes both lanes through untouched. In DMR mode both cores
 * get the leader's inputs, their results are compared and only the
 * leader's result reaches the system. A mismatch pulses error_o and sets
 * back both cores one cycle later.
 */

`timescale 1ns/100ps

module dmr_checker (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            dmr_en_i,
  // System side
  input  logic [1:0]                      sys_valid_i,
  input  logic [1:0][hmr_pkg::DATA_W-1:0] sys_data_i,
  input  logic [1:0][hmr_pkg::ID_W-1:0]   sys_id_i,
  output logic [1:0]                      sys_valid_o,
  output logic [1:0][hmr_pkg::DATA_W-1:0] sys_data_o,
  output logic [1:0][hmr_pkg::ID_W-1:0]   sys_id_o,
  // Core side
  output logic [1:0]                      core_valid_o,
  output logic [1:0][hmr_pkg::DATA_W-1:0] core_data_o,
  output logic [1:0][hmr_pkg::ID_W-1:0]   core_id_o,
  input  logic [1:0]                      core_valid_i,
  input  logic [1:0][hmr_pkg::DATA_W-1:0] core_data_i,
  input  logic [1:0][hmr_pkg::ID_W-1:0]   core_id_i,
  output logic [1:0]                      setback_o,
  output logic                            error_o
);

  logic both_valid;
  logic diverged;
  logic mismatch;
  logic setback_q;

  // Input steering, the follower copies the leader in DMR mode
  always_comb begin
    core_valid_o[0] = sys_valid_i[0];
    core_data_o[0]  = sys_data_i[0];
    core_id_o[0]    = sys_id_i[0];
    if (dmr_en_i) begin
      core_valid_o[1] = sys_valid_i[0];
      core_data_o[1]  = sys_data_i[0];
      core_id_o[1]    = sys_id_i[0];
    end else begin
      core_valid_o[1] = sys_valid_i[1];
      core_data_o[1]  = sys_data_i[1];
      core_id_o[1]    = sys_id_i[1];
    end
  end

  // Only results produced in the same cycle are compared
  assign both_valid = core_valid_i[0] & core_valid_i[1];
  assign diverged   = (core_data_i[0] != core_data_i[1]) | (core_id_i[0] != core_id_i[1]);
  assign mismatch   = dmr_en_i & both_valid & diverged;

  // Output forwarding
  always_comb begin
    sys_valid_o[0] = core_valid_i[0] & ~mismatch;   // Drop a disputed result
    sys_valid_o[1] = core_valid_i[1] & ~dmr_en_i;   // Follower silent in DMR
    sys_data_o     = core_data_i;
    sys_id_o       = core_id_i;
  end

  assign error_o = mismatch;

  // Setback follows the mismatch by one edge, for both cores
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      setback_q <= 1'b0;
    end else begin
      setback_q <= mismatch;
    end
  end

  assign setback_o = {2{setback_q}};

endmodule : dmr_checker

//--- logic/hmr_pkg.sv
/*
 * Shared widths, register map and counter limits for the DMR core cluster.
 * Every design file refers to these by scoped names, without an import.
 */

package hmr_pkg;

  // Datapath widths
  localparam int unsigned DATA_W = 32;  // Core operands and results
  localparam int unsigned ID_W   = 16;  // Hart id carried with each result

  // Register port widths
  localparam int unsigned REG_AW = 8;
  localparam int unsigned REG_DW = 32;

  // One mismatch counter per core pair, saturating
  localparam int unsigned CNT_W = 8;
  localparam logic [CNT_W-1:0] CNT_MAX = '1;  // Stops at 255

  /*
   * Register map
   *   0      DMR enable, one bit per pair, read/write
   *   1 + p  Mismatch counter of pair p, any write clears it
   * Everything else reads as zero
   */
  localparam logic [REG_AW-1:0] ADDR_DMR_EN   = 8'h00;
  localparam logic [REG_AW-1:0] ADDR_ERR_BASE = 8'h01;

endpackage : hmr_pkg

//--- logic/hmr_regs.sv
/*
 * Configuration and status registers of the redundancy unit.
 * Holds the per-pair DMR enable bits and one saturating mismatch counter
 * per pair. Writes act on the edge they are seen, read data appears on
 * the cycle after a read strobe and holds until the next read.
 */

`timescale 1ns/100ps

module hmr_regs #(
  parameter  int unsigned NUM_CORES = 4,
  localparam int unsigned NUM_PAIRS = NUM_CORES / 2
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        reg_we_i,
  input  logic                        reg_re_i,
  input  logic [hmr_pkg::REG_AW-1:0]  reg_addr_i,
  input  logic [hmr_pkg::REG_DW-1:0]  reg_wdata_i,
  input  logic [NUM_PAIRS-1:0]        pair_error_i,
  output logic [hmr_pkg::REG_DW-1:0]  reg_rdata_o,
  output logic [NUM_PAIRS-1:0]        dmr_en_o
);

  logic                                  en_sel;
  logic [NUM_PAIRS-1:0]                  cnt_sel;  // Address hits a counter
  logic [NUM_PAIRS-1:0][hmr_pkg::CNT_W-1:0] cnt_q;
  logic [NUM_PAIRS-1:0]                  dmr_en_q;
  logic [hmr_pkg::REG_DW-1:0]            rdata_next;

  assign en_sel = (reg_addr_i == hmr_pkg::ADDR_DMR_EN);

  // DMR enable register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dmr_en_q <= '0;
    end else if (reg_we_i && en_sel) begin
      dmr_en_q <= reg_wdata_i[NUM_PAIRS-1:0];
    end
  end

  assign dmr_en_o = dmr_en_q;

  // Mismatch counters, one per pair
  for (genvar p = 0; p < NUM_PAIRS; p++) begin : gen_err_cnt
    localparam logic [hmr_pkg::REG_AW-1:0] CNT_ADDR = hmr_pkg::ADDR_ERR_BASE + p;

    assign cnt_sel[p] = (reg_addr_i == CNT_ADDR);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_q[p] <= '0;
      end else if (reg_we_i && cnt_sel[p]) begin
        cnt_q[p] <= '0;  // Clear wins over a same-cycle error
      end else if (pair_error_i[p] && (cnt_q[p] != hmr_pkg::CNT_MAX)) begin
        cnt_q[p] <= cnt_q[p] + 1'b1;
      end
    end
  end

  // Read decode, unmapped addresses give zero
  always_comb begin
    rdata_next = '0;
    if (en_sel) begin
      rdata_next[NUM_PAIRS-1:0] = dmr_en_q;
    end
    for (int p = 0; p < NUM_PAIRS; p++) begin
      if (cnt_sel[p]) begin
        rdata_next[hmr_pkg::CNT_W-1:0] = cnt_q[p];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      reg_rdata_o <= rdata_next;  // Held until the next read
    end
  end

endmodule : hmr_regs

//--- logic/hmr_unit.sv
/*
 * Redundancy unit placed between the system ports and the cores.
 * Groups the cores into adjacent pairs, each with its own checker, and
 * keeps the register block that selects DMR mode and counts mismatches.
 */

`timescale 1ns/100ps

module hmr_unit #(
  parameter  int unsigned NUM_CORES = 4,
  localparam int unsigned NUM_PAIRS = NUM_CORES / 2
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  // Register port
  input  logic                                    reg_we_i,
  input  logic                                    reg_re_i,
  input  logic [hmr_pkg::REG_AW-1:0]              reg_addr_i,
  input  logic [hmr_pkg::REG_DW-1:0]              reg_wdata_i,
  output logic [hmr_pkg::REG_DW-1:0]              reg_rdata_o,
  // System side, one entry per core
  input  logic [NUM_CORES-1:0]                    sys_valid_i,
  input  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] sys_data_i,
  input  logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   sys_id_i,
  output logic [NUM_CORES-1:0]                    sys_valid_o,
  output logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] sys_data_o,
  output logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   sys_id_o,
  // Core side, one entry per core
  output logic [NUM_CORES-1:0]                    core_valid_o,
  output logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] core_data_o,
  output logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   core_id_o,
  output logic [NUM_CORES-1:0]                    core_setback_o,
  input  logic [NUM_CORES-1:0]                    core_valid_i,
  input  logic [NUM_CORES-1:0][hmr_pkg::DATA_W-1:0] core_data_i,
  input  logic [NUM_CORES-1:0][hmr_pkg::ID_W-1:0]   core_id_i,
  output logic [NUM_PAIRS-1:0]                    dmr_error_o
);

  logic [NUM_PAIRS-1:0] dmr_en;

  hmr_regs #(
    .NUM_CORES ( NUM_CORES )
  ) u_hmr_regs (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .reg_we_i     ( reg_we_i    ),
    .reg_re_i     ( reg_re_i    ),
    .reg_addr_i   ( reg_addr_i  ),
    .reg_wdata_i  ( reg_wdata_i ),
    .pair_error_i ( dmr_error_o ),  // Error pulses feed the counters
    .reg_rdata_o  ( reg_rdata_o ),
    .dmr_en_o     ( dmr_en      )
  );

  // Cores 2p and 2p+1 form pair p, the even core leads
  for (genvar p = 0; p < NUM_PAIRS; p++) begin : gen_pairs
    dmr_checker u_dmr_checker (
      .clk_i        ( clk_i                    ),
      .reset_i      ( reset_i                  ),
      .dmr_en_i     ( dmr_en[p]                ),
      .sys_valid_i  ( sys_valid_i[2*p +: 2]    ),
      .sys_data_i   ( sys_data_i[2*p +: 2]     ),
      .sys_id_i     ( sys_id_i[2*p +: 2]       ),
      .sys_valid_o  ( sys_valid_o[2*p +: 2]    ),
      .sys_data_o   ( sys_data_o[2*p +: 2]     ),
      .sys_id_o     ( sys_id_o[2*p +: 2]       ),
      .core_valid_o ( core_valid_o[2*p +: 2]   ),
      .core_data_o  ( core_data_o[2*p +: 2]    ),
      .core_id_o    ( core_id_o[2*p +: 2]      ),
      .core_valid_i ( core_valid_i[2*p +: 2]   ),
      .core_data_i  ( core_data_i[2*p +: 2]    ),
      .core_id_i    ( core_id_i[2*p +: 2]      ),
      .setback_o    ( core_setback_o[2*p +: 2] ),
      .error_o      ( dmr_error_o[p]           )
    );
  end

endmodule : hmr_unit

//--- logic/work_core.sv
/*
 * Small accumulator core used as the redundant worker.
 * Each input strobe adds its data to a running sum and one cycle later
 * returns the new sum tagged with the hart id it was given.
 * A setback restarts the sum from zero, still taking a same-cycle strobe.
 */

`timescale 1ns/100ps

module work_core (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      setback_i,
  input  logic                      valid_i,
  input  logic [hmr_pkg::DATA_W-1:0] data_i,
  input  logic [hmr_pkg::ID_W-1:0]   hart_id_i,
  output logic                      valid_o,
  output logic [hmr_pkg::DATA_W-1:0] data_o,
  output logic [hmr_pkg::ID_W-1:0]   id_o
);

  logic [hmr_pkg::DATA_W-1:0] acc_q;     // Running sum
  logic [hmr_pkg::DATA_W-1:0] acc_base;  // Sum after an optional setback
  logic [hmr_pkg::DATA_W-1:0] acc_next;

  // Setback drops the old sum before the new data is added
  always_comb begin
    acc_base = setback_i ? '0 : acc_q;
    if (valid_i) begin
      acc_next = acc_base + data_i;
    end else begin
      acc_next = acc_base;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q   <= '0;
      valid_o <= 1'b0;
    end else begin
      acc_q   <= acc_next;
      valid_o <= valid_i;  // One result per strobe
    end
  end

  // Result payload, only loaded with a strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o <= acc_next;
      id_o   <= hart_id_i;  // Echo of the id seen with the strobe
    end
  end

endmodule : work_core
